/* soc_pkg.sv */
package soc_pkg;

    // Data word on the memory bus
    typedef logic [31:0] word_t;

    // One bus request, shared by every device behind the decoder
    typedef struct packed {
        logic [31:0] address;
        logic        read;
        logic [3:0]  write_mask;
        word_t       write_value;
    } mem_req_t;

    // SPI flash READ opcode
    localparam logic [7:0] FLASH_CMD_READ = 8'h03;

    // Flash window, 16 MiB, low bits go straight to the flash
    localparam logic [31:0] FLASH_BASE      = 32'h0100_0000;
    localparam int          FLASH_ADDR_BITS = 24;

    // On-chip RAM window, 1 KiB
    localparam logic [31:0] RAM_BASE      = 32'h0000_0000;
    localparam int          RAM_WORDS     = 256;
    localparam int          RAM_ADDR_BITS = $clog2(RAM_WORDS); // Word index width

    // Flash read controller states
    typedef enum logic [1:0] {
        FLASH_IDLE      = 2'b00,
        FLASH_WRITE_CMD = 2'b01,
        FLASH_READ_DATA = 2'b10,
        FLASH_DONE      = 2'b11
    } flash_state_t;

endpackage

/* bus_decoder.sv */
`timescale 1ns/1ns

module bus_decoder (
    input  logic               clk,
    input  logic               reset,

    input  logic               sel,
    input  soc_pkg::mem_req_t  req,
    output soc_pkg::word_t     read_value,
    output logic               ready,

    output logic               flash_sel,
    output logic               ram_sel,
    input  soc_pkg::word_t     flash_read_value,
    input  soc_pkg::word_t     ram_read_value,
    input  logic               flash_ready,
    input  logic               ram_ready
);
    import soc_pkg::*;

    localparam int RAM_WINDOW_BITS = RAM_ADDR_BITS + 2;

    logic flash_hit;
    logic ram_hit;
    logic local_sel;   // Flash write or unmapped access
    logic local_ready;
    logic local_done;

    assign flash_hit = req.address[31:FLASH_ADDR_BITS] == FLASH_BASE[31:FLASH_ADDR_BITS];
    assign ram_hit   = req.address[31:RAM_WINDOW_BITS] == RAM_BASE[31:RAM_WINDOW_BITS];

    // Flash is read only, its controller never finishes a write
    assign flash_sel = sel && flash_hit && req.read;
    assign ram_sel   = sel && ram_hit;
    assign local_sel = sel && !flash_sel && !ram_sel;

    always_comb begin
        if (flash_sel) begin
            read_value = flash_read_value;
            ready      = flash_ready;
        end else if (ram_sel) begin
            read_value = ram_read_value;
            ready      = ram_ready;
        end else begin
            read_value = '0;          // Unmapped reads return zero
            ready      = local_ready;
        end
    end

    // Complete dropped and unmapped accesses one cycle after sel
    always_ff @(posedge clk) begin
        if (reset) begin
            local_ready <= 1'b0;
            local_done  <= 1'b0;
        end else begin
            local_ready <= local_sel && !local_done;
            if (local_sel && !local_done) begin
                local_done <= 1'b1;
            end else if (!local_sel || local_ready) begin
                local_done <= 1'b0;
            end
        end
    end

endmodule

/* flash.sv */
`timescale 1ns/1ns

module flash (
    input  logic               clk,
    input  logic               reset,

    input  logic               sel,
    input  soc_pkg::mem_req_t  req,
    output soc_pkg::word_t     read_value,
    output logic               ready,

    output logic               spi_clk,
    output logic               spi_csn,
    output logic               spi_mosi,
    input  logic               spi_miso
);
    import soc_pkg::*;

    flash_state_t state;
    logic [4:0]   bits;  // Bits left in the current phase
    word_t        shift; // Command and address out, then data in

    assign spi_clk = clk;
    assign spi_csn = !(state == FLASH_WRITE_CMD || state == FLASH_READ_DATA);

    // Flash byte 0 arrives first, so it ends up in the top byte of shift
    assign read_value = sel ? {shift[7:0], shift[15:8], shift[23:16], shift[31:24]} : '0;
    assign ready      = sel && state == FLASH_DONE;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= FLASH_IDLE;
            bits     <= '0;
            spi_mosi <= 1'b0;
        end else begin
            case (state)
                FLASH_IDLE: begin
                    if (sel && req.read) begin
                        state    <= FLASH_WRITE_CMD;
                        bits     <= 5'd31;
                        spi_mosi <= FLASH_CMD_READ[7]; // Opcode MSB goes out right away
                        shift    <= {FLASH_CMD_READ[6:0], req.address[FLASH_ADDR_BITS-1:0],
                                     1'b0};
                    end else begin
                        spi_mosi <= 1'b0;
                    end
                end

                FLASH_WRITE_CMD: begin
                    if (|bits) begin
                        bits     <= bits - 5'd1;
                        spi_mosi <= shift[31];
                        shift    <= {shift[30:0], 1'b0};
                    end else begin
                        // Last address bit is being sampled by the flash on this edge
                        state    <= FLASH_READ_DATA;
                        bits     <= 5'd31;
                        spi_mosi <= 1'b0;
                    end
                end

                FLASH_READ_DATA: begin
                    if (|bits) begin
                        bits <= bits - 5'd1;
                    end else begin
                        state <= FLASH_DONE;
                    end
                    shift <= {shift[30:0], spi_miso}; // MSB first
                end

                FLASH_DONE: begin
                    state <= FLASH_IDLE;
                end

                default: begin
                    state <= FLASH_IDLE;
                end
            endcase
        end
    end

endmodule

/* ram.sv */
`timescale 1ns/1ns

module ram (
    input  logic               clk,
    input  logic               reset,

    input  logic               sel,
    input  soc_pkg::mem_req_t  req,
    output soc_pkg::word_t     read_value,
    output logic               ready
);
    import soc_pkg::*;

    word_t                    mem [RAM_WORDS];
    logic [RAM_ADDR_BITS-1:0] index;
    word_t                    read_word;
    logic                     busy; // Request already answered

    assign index      = req.address[RAM_ADDR_BITS+1:2];
    assign read_value = read_word;

    // Storage and read port
    always_ff @(posedge clk) begin
        if (sel && !busy) begin
            if (!req.read) begin
                for (int i = 0; i < 4; i++) begin
                    if (req.write_mask[i]) begin
                        mem[index][i*8 +: 8] <= req.write_value[i*8 +: 8];
                    end
                end
            end
            read_word <= mem[index];
        end
    end

    // One ready pulse per request
    always_ff @(posedge clk) begin
        if (reset) begin
            ready <= 1'b0;
            busy  <= 1'b0;
        end else begin
            ready <= sel && !busy;
            if (sel && !busy) begin
                busy <= 1'b1;
            end else if (!sel || ready) begin
                busy <= 1'b0; // Master may hold sel for a back-to-back request
            end
        end
    end

endmodule

/* mem_subsystem.sv */
`timescale 1ns/1ns

module mem_subsystem (
    input  logic               clk,
    input  logic               reset,

    input  logic               sel,
    input  soc_pkg::mem_req_t  req,
    output soc_pkg::word_t     read_value,
    output logic               ready,

    output logic               spi_clk,
    output logic               spi_csn,
    output logic               spi_mosi,
    input  logic               spi_miso
);
    import soc_pkg::*;

    logic  flash_sel;
    logic  flash_ready;
    word_t flash_read_value;
    logic  ram_sel;
    logic  ram_ready;
    word_t ram_read_value;

    bus_decoder bus_decoder (
        .clk              (clk),
        .reset            (reset),
        .sel              (sel),
        .req              (req),
        .read_value       (read_value),
        .ready            (ready),
        .flash_sel        (flash_sel),
        .ram_sel          (ram_sel),
        .flash_read_value (flash_read_value),
        .ram_read_value   (ram_read_value),
        .flash_ready      (flash_ready),
        .ram_ready        (ram_ready)
    );

    flash flash (
        .clk        (clk),
        .reset      (reset),
        .sel        (flash_sel),
        .req        (req),
        .read_value (flash_read_value),
        .ready      (flash_ready),
        .spi_clk    (spi_clk),
        .spi_csn    (spi_csn),
        .spi_mosi   (spi_mosi),
        .spi_miso   (spi_miso)
    );

    ram ram (
        .clk        (clk),
        .reset      (reset),
        .sel        (ram_sel),
        .req        (req),
        .read_value (ram_read_value),
        .ready      (ram_ready)
    );

endmodule

/* spi_flash_model.sv */
`timescale 1ns/1ns

module spi_flash_model (
    input  logic        spi_clk,
    input  logic        spi_csn,
    input  logic        spi_mosi,
    output logic        spi_miso,
    output logic [7:0]  cmd,       // Last opcode received
    output logic [23:0] address,   // Last address received
    output int          transfers  // Completed command phases
);
    import soc_pkg::*;

    logic [7:0]  mem [1024]; // Filled by the testbench, mirrored over the 16 MiB window
    logic [31:0] rx_shift;
    int          rx_count;
    int          tx_count;
    logic [31:0] data;
    logic [9:0]  base;

    initial begin
        spi_miso  = 1'b0;
        cmd       = '0;
        address   = '0;
        transfers = 0;
        rx_count  = 0;
        tx_count  = 0;
        rx_shift  = '0;
        data      = '0;
    end

    // Opcode and address come in MSB first on the rising edge
    always @(posedge spi_clk) begin
        if (spi_csn) begin
            rx_count = 0;
        end else if (rx_count < 32) begin
            rx_shift = {rx_shift[30:0], spi_mosi};
            rx_count = rx_count + 1;
            if (rx_count == 32) begin
                cmd       = rx_shift[31:24];
                address   = rx_shift[23:0];
                base      = rx_shift[9:0];
                transfers = transfers + 1;
                if (cmd == FLASH_CMD_READ) begin
                    data = {mem[base], mem[base + 10'd1], mem[base + 10'd2], mem[base + 10'd3]};
                end else begin
                    data = '0; // Only READ is decoded
                end
            end
        end
    end

    // Data goes out on the falling edge so it is stable at the next rising edge
    always @(negedge spi_clk) begin
        if (spi_csn) begin
            tx_count = 0;
            spi_miso = 1'b0;
        end else if (rx_count == 32 && tx_count < 32) begin
            spi_miso = data[31 - tx_count];
            tx_count = tx_count + 1;
        end
    end

endmodule

/* mem_subsystem_tb.sv */
`timescale 1ns/1ns

module mem_subsystem_tb;
    import soc_pkg::*;

    localparam logic [31:0] LFSR_SEED = 32'd67993;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1

    localparam int FLASH_LATENCY    = 65; // 32 command cycles, 32 data cycles, one done cycle
    localparam int NUM_FLASH_READS  = 12;
    localparam int NUM_RAM_OPS      = 40;
    localparam int NUM_FLASH_WRITES = 6;
    localparam int NUM_UNMAPPED     = 8;
    localparam int NUM_MIXED        = 48;
    localparam int NUM_TRANSACTIONS = NUM_FLASH_READS + RAM_WORDS + 2 * NUM_RAM_OPS
                                      + 2 * NUM_FLASH_WRITES + NUM_UNMAPPED + NUM_MIXED;
    localparam int TIMEOUT_CYCLES   = NUM_TRANSACTIONS * 80 + 100;

    logic     clk;
    logic     reset;
    logic     sel;
    mem_req_t req;
    word_t    read_value;
    logic     ready;
    logic     spi_clk;
    logic     spi_csn;
    logic     spi_mosi;
    logic     spi_miso;

    logic [7:0]  flash_cmd;
    logic [23:0] flash_address;
    int          flash_transfers;

    logic [31:0] lfsr_state;
    logic [7:0]  flash_bytes [1024];
    word_t       ram_model [RAM_WORDS];

    mem_subsystem UUT (
        .clk        (clk),
        .reset      (reset),
        .sel        (sel),
        .req        (req),
        .read_value (read_value),
        .ready      (ready),
        .spi_clk    (spi_clk),
        .spi_csn    (spi_csn),
        .spi_mosi   (spi_mosi),
        .spi_miso   (spi_miso)
    );

    spi_flash_model flash_model (
        .spi_clk   (spi_clk),
        .spi_csn   (spi_csn),
        .spi_mosi  (spi_mosi),
        .spi_miso  (spi_miso),
        .cmd       (flash_cmd),
        .address   (flash_address),
        .transfers (flash_transfers)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? (state >> 1) ^ LFSR_TAPS : state >> 1;
    endfunction

    function automatic word_t random_bits(input int count);
        word_t value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    function automatic logic [3:0] nonzero_mask();
        word_t m;
        m = random_bits(4);
        return (m == 0) ? 4'hF : m[3:0];
    endfunction

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // One bus transaction with ready and chip select checked on every cycle
    task automatic access(input mem_req_t r, input int latency, input logic flash_transfer,
                          output word_t data);
        @(negedge clk);
        sel = 1'b1;
        req = r;
        for (int k = 1; k <= latency; k++) begin
            @(negedge clk);
            check_bit("spi_csn", spi_csn, !(flash_transfer && k < latency));
            check_bit("ready", ready, k == latency);
        end
        data = read_value;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            sel = 1'b0;
        end
    endtask

    task automatic flash_read(input word_t offset);
        mem_req_t   r;
        word_t      data;
        word_t      expected;
        logic [9:0] base;
        int         transfers;

        r.address     = FLASH_BASE | {8'h00, offset[23:2], 2'b00};
        r.read        = 1'b1;
        r.write_mask  = 4'h0;
        r.write_value = '0;
        base          = {offset[9:2], 2'b00};
        // Flash byte 0 sits in the low byte of the bus word
        expected  = {flash_bytes[base + 10'd3], flash_bytes[base + 10'd2],
                     flash_bytes[base + 10'd1], flash_bytes[base]};
        transfers = flash_transfers;
        access(r, FLASH_LATENCY, 1'b1, data);
        check_word("read_value", data, expected);
        check_word("flash cmd", word_t'(flash_cmd), word_t'(FLASH_CMD_READ));
        check_word("flash address", word_t'(flash_address), r.address & 32'h00ff_ffff);
        check_word("flash transfers", word_t'(flash_transfers), word_t'(transfers + 1));
    endtask

    task automatic flash_write(input word_t offset);
        mem_req_t r;
        word_t    data;
        int       transfers;

        r.address     = FLASH_BASE | {8'h00, offset[23:2], 2'b00};
        r.read        = 1'b0;
        r.write_mask  = nonzero_mask();
        r.write_value = random_bits(32);
        transfers     = flash_transfers;
        access(r, 1, 1'b0, data);
        check_word("flash transfers", word_t'(flash_transfers), word_t'(transfers));
    endtask

    task automatic ram_write(input word_t index, input logic [3:0] mask, input word_t value);
        mem_req_t r;
        word_t    data;

        r.address     = RAM_BASE | (word_t'(index[RAM_ADDR_BITS-1:0]) << 2);
        r.read        = 1'b0;
        r.write_mask  = mask;
        r.write_value = value;
        access(r, 1, 1'b0, data);
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                ram_model[index[RAM_ADDR_BITS-1:0]][b*8 +: 8] = value[b*8 +: 8];
            end
        end
    endtask

    task automatic ram_read(input word_t index);
        mem_req_t r;
        word_t    data;

        r.address     = RAM_BASE | (word_t'(index[RAM_ADDR_BITS-1:0]) << 2);
        r.read        = 1'b1;
        r.write_mask  = 4'h0;
        r.write_value = '0;
        access(r, 1, 1'b0, data);
        check_word("read_value", data, ram_model[index[RAM_ADDR_BITS-1:0]]);
    endtask

    task automatic unmapped_read();
        mem_req_t r;
        word_t    data;

        if (random_bits(1)) begin
            r.address = random_bits(32) | 32'h0200_0000; // Top byte 0x02 or above
        end else begin
            r.address = random_bits(24) | 32'h0000_0400; // Gap between RAM and flash
        end
        r.read        = 1'b1;
        r.write_mask  = 4'h0;
        r.write_value = '0;
        access(r, 1, 1'b0, data);
        check_word("read_value", data, '0);
    endtask

    initial begin
        word_t      index;
        logic [3:0] mask;
        word_t      value;
        word_t      offset;

        clk        = 1'b0;
        reset      = 1'b1;
        sel        = 1'b0;
        req        = '0;
        lfsr_state = LFSR_SEED;
        for (int i = 0; i < 1024; i++) begin
            flash_bytes[i]     = 8'(random_bits(8));
            flash_model.mem[i] = flash_bytes[i];
        end
        repeat (3) @(negedge clk);
        reset = 1'b0;

        @(negedge clk);
        check_bit("spi_csn", spi_csn, 1'b1);
        check_bit("ready", ready, 1'b0);

        for (int i = 0; i < NUM_FLASH_READS; i++) begin
            flash_read(random_bits(24));
        end
        idle(2);

        // Whole RAM gets a known value first
        for (int i = 0; i < RAM_WORDS; i++) begin
            value = random_bits(32);
            ram_write(word_t'(i), 4'hF, value);
        end
        for (int i = 0; i < NUM_RAM_OPS; i++) begin
            index = random_bits(RAM_ADDR_BITS);
            mask  = nonzero_mask();
            value = random_bits(32);
            ram_write(index, mask, value);
            ram_read(index);
        end
        idle(2);

        for (int i = 0; i < NUM_FLASH_WRITES; i++) begin
            offset = random_bits(24);
            flash_write(offset);
            flash_read(offset);
        end
        for (int i = 0; i < NUM_UNMAPPED; i++) begin
            unmapped_read();
        end
        idle(2);

        for (int i = 0; i < NUM_MIXED; i++) begin
            case (random_bits(3))
                0, 7: flash_read(random_bits(24));
                1: flash_write(random_bits(24));
                2, 3: begin
                    index = random_bits(RAM_ADDR_BITS);
                    mask  = nonzero_mask();
                    value = random_bits(32);
                    ram_write(index, mask, value);
                end
                4, 5: ram_read(random_bits(RAM_ADDR_BITS));
                default: unmapped_read();
            endcase
            idle(int'(random_bits(2)));
        end
        idle(2);

        $display("STATUS: PASS");
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("STATUS: FAIL");
        $fatal(1, "Watchdog expired");
    end

endmodule

/* sim.f */
soc_pkg.sv
bus_decoder.sv
flash.sv
ram.sv
mem_subsystem.sv
spi_flash_model.sv
mem_subsystem_tb.sv

/* Bender.yml */
package:
  name: mem_subsystem

sources:
  - soc_pkg.sv
  - bus_decoder.sv
  - flash.sv
  - ram.sv
  - mem_subsystem.sv
  - target: test
    files:
      - spi_flash_model.sv
      - mem_subsystem_tb.sv
